//--- src/rv_core.sv
`timescale 1ns/100ps

module rv_core (
  input  logic              clk,
  input  logic              rst_n,
  output rv_pkg::word_t     imem_raddr,
  input  rv_pkg::word_t     imem_rdata,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_pc,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_data,
  output logic              ebreak,
  output logic              trap
);

  // Register file read port
  rv_pkg::reg_addr_t  rs1;
  rv_pkg::reg_addr_t  rs2;
  rv_pkg::word_t      rs1_data;
  rv_pkg::word_t      rs2_data;

  // Stage registers and the write-back path
  rv_pkg::ex_stage_t  ex;
  rv_pkg::res_stage_t res;
  rv_pkg::wb_t        wb;
  logic               halt;

  // ----------------------------------------
  // Decode, execute, result
  // ----------------------------------------

  rv_decode i_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .halt       (halt),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .rs1        (rs1),
    .rs2        (rs2),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .ex         (ex)
  );

  // Written from result, read in decode
  rv_regfile i_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  rv_execute i_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .ex    (ex),
    .wb    (wb),
    .res   (res)
  );

  rv_result i_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .res          (res),
    .wb           (wb),
    .halt         (halt),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .ebreak       (ebreak),
    .trap         (trap)
  );

endmodule

//--- src/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              halt,
  output rv_pkg::word_t     imem_raddr,
  input  rv_pkg::word_t     imem_rdata,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  output rv_pkg::ex_stage_t ex
);

  rv_pkg::word_t     pc;
  rv_pkg::instr_u    instr;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_u;
  rv_pkg::word_t     imm_shamt;
  logic              shift_alt;
  rv_pkg::ex_stage_t ex_next;

  // funct3 to ALU op, alt selects SUB or SRA
  function automatic rv_pkg::alu_op_t f3_to_op(input logic [2:0] funct3, input logic alt);
    rv_pkg::alu_op_t op;
    op = rv_pkg::alu_add;
    case (funct3)
      rv_pkg::f3_add_sub: op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:     op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     op = rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      op = rv_pkg::alu_or;
      rv_pkg::f3_and:     op = rv_pkg::alu_and;
      default:            op = rv_pkg::alu_add;
    endcase
    return op;
  endfunction

  // ----------------------------------------
  // PC and fetch
  // ----------------------------------------

  // PC freezes once the core halts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= rv_pkg::reset_pc;
    end else if (!halt) begin
      pc <= pc + rv_pkg::pc_step;
    end
  end

  // Zero-latency memory, word comes back this cycle
  assign imem_raddr = pc;
  assign instr      = imem_rdata;

  // Register file reads straight from the fields
  assign rs1 = instr.r_fmt.rs1;
  assign rs2 = instr.r_fmt.rs2;

  // ----------------------------------------
  // Field decode
  // ----------------------------------------

  // Sign-extended I immediate
  assign imm_i = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
  // Upper immediate, low 12 bits clear
  assign imm_u = {instr.u_fmt.imm20, 12'b0};
  // Shift amount sits in the rs2 slot of an OP-IMM shift
  assign imm_shamt = {27'b0, instr.r_fmt.rs2};
  // Only right shifts may carry the alt funct7
  assign shift_alt = (instr.r_fmt.funct3 == rv_pkg::f3_srl_sra) && instr.r_fmt.funct7[5];

  always_comb begin
    ex_next            = '0;
    ex_next.valid      = !halt;
    ex_next.pc         = pc;
    ex_next.rs1        = instr.r_fmt.rs1;
    ex_next.rs2        = instr.r_fmt.rs2;
    ex_next.rd         = instr.r_fmt.rd;
    ex_next.rs1_data   = rs1_data;
    ex_next.rs2_data   = rs2_data;
    ex_next.imm        = imm_i;
    ex_next.alu_op     = rv_pkg::alu_add;
    ex_next.is_illegal = 1'b0;

    case (instr.r_fmt.opcode)
      rv_pkg::op_rtype: begin
        ex_next.alu_op    = f3_to_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
        ex_next.reg_write = 1'b1;
        // Alt funct7 only for SUB and SRA
        if (instr.r_fmt.funct7 == rv_pkg::funct7_alt) begin
          ex_next.is_illegal = (instr.r_fmt.funct3 != rv_pkg::f3_add_sub) &&
                               (instr.r_fmt.funct3 != rv_pkg::f3_srl_sra);
        end else begin
          ex_next.is_illegal = (instr.r_fmt.funct7 != rv_pkg::funct7_base);
        end
      end

      rv_pkg::op_itype: begin
        ex_next.alu_op    = f3_to_op(instr.i_fmt.funct3, shift_alt);
        ex_next.use_imm   = 1'b1;
        ex_next.reg_write = 1'b1;
        if (instr.i_fmt.funct3 == rv_pkg::f3_sll) begin
          ex_next.imm        = imm_shamt;
          ex_next.is_illegal = (instr.r_fmt.funct7 != rv_pkg::funct7_base);
        end else if (instr.i_fmt.funct3 == rv_pkg::f3_srl_sra) begin
          ex_next.imm        = imm_shamt;
          ex_next.is_illegal = (instr.r_fmt.funct7 != rv_pkg::funct7_base) &&
                               (instr.r_fmt.funct7 != rv_pkg::funct7_alt);
        end
      end

      rv_pkg::op_lui: begin
        ex_next.imm       = imm_u;
        ex_next.alu_op    = rv_pkg::alu_pass_b;
        ex_next.use_imm   = 1'b1;
        ex_next.reg_write = 1'b1;
      end

      // PC plus upper immediate
      rv_pkg::op_auipc: begin
        ex_next.imm       = imm_u;
        ex_next.use_imm   = 1'b1;
        ex_next.use_pc    = 1'b1;
        ex_next.reg_write = 1'b1;
      end

      // EBREAK only, ECALL and CSR forms trap
      rv_pkg::op_system: begin
        ex_next.is_ebreak  = (imem_rdata == rv_pkg::funct_ebreak);
        ex_next.is_illegal = (imem_rdata != rv_pkg::funct_ebreak);
      end

      default: begin
        ex_next.is_illegal = 1'b1;
      end
    endcase
  end

  // ----------------------------------------
  // Decode to execute register
  // ----------------------------------------

  // Payload loads every cycle, only valid is cleared
  always_ff @(posedge clk) begin
    ex <= ex_next;
    if (!rst_n) begin
      ex.valid <= 1'b0;
    end
  end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_pkg::ex_stage_t  ex,
  input  rv_pkg::wb_t        wb,
  output rv_pkg::res_stage_t res
);

  rv_pkg::word_t      rs1_val;
  rv_pkg::word_t      rs2_val;
  rv_pkg::word_t      op_a;
  rv_pkg::word_t      op_b;
  logic [4:0]         shamt;
  rv_pkg::word_t      alu_y;
  rv_pkg::res_stage_t res_next;

  // Result-stage bypass for one source
  // x0 never takes a forwarded value
  function automatic rv_pkg::word_t fwd_sel(
    input rv_pkg::reg_addr_t src,
    input rv_pkg::word_t     reg_val,
    input rv_pkg::wb_t       wb_in
  );
    rv_pkg::word_t val;
    val = reg_val;
    if (wb_in.en && (src != '0) && (wb_in.addr == src)) begin
      val = wb_in.data;
    end
    return val;
  endfunction

  // ----------------------------------------
  // Operand select
  // ----------------------------------------

  // Instruction one ahead is in result now
  assign rs1_val = fwd_sel(ex.rs1, ex.rs1_data, wb);
  assign rs2_val = fwd_sel(ex.rs2, ex.rs2_data, wb);

  // A is the PC for AUIPC
  assign op_a = ex.use_pc ? ex.pc : rs1_val;
  // B is the immediate for OP-IMM, LUI and AUIPC
  assign op_b = ex.use_imm ? ex.imm : rs2_val;

  assign shamt = op_b[4:0];

  // ----------------------------------------
  // ALU
  // ----------------------------------------

  always_comb begin
    case (ex.alu_op)
      rv_pkg::alu_add:    alu_y = op_a + op_b;
      rv_pkg::alu_sub:    alu_y = op_a - op_b;
      rv_pkg::alu_sll:    alu_y = op_a << shamt;
      rv_pkg::alu_slt:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu:   alu_y = {31'b0, op_a < op_b};
      rv_pkg::alu_xor:    alu_y = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_y = op_a >> shamt;
      rv_pkg::alu_sra:    alu_y = rv_pkg::word_t'($signed(op_a) >>> shamt);
      rv_pkg::alu_or:     alu_y = op_a | op_b;
      rv_pkg::alu_and:    alu_y = op_a & op_b;
      rv_pkg::alu_pass_b: alu_y = op_b;
      default:            alu_y = '0;
    endcase
  end

  // Carry the item on with its outcome
  always_comb begin
    res_next.valid      = ex.valid;
    res_next.pc         = ex.pc;
    res_next.rd         = ex.rd;
    res_next.result     = alu_y;
    res_next.reg_write  = ex.reg_write;
    res_next.is_ebreak  = ex.is_ebreak;
    res_next.is_illegal = ex.is_illegal;
  end

  // ----------------------------------------
  // Execute to result register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    res <= res_next;
    if (!rst_n) begin
      res.valid <= 1'b0;
    end
  end

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

  // ----------------------------------------
  // Widths and fetch constants
  // ----------------------------------------

  localparam int xlen = 32;
  localparam int reg_aw = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_aw-1:0] reg_addr_t;

  // First fetch address after reset
  localparam word_t reset_pc = '0;
  // Sequential fetch step, one 32-bit instruction
  localparam word_t pc_step = 32'd4;

  // ----------------------------------------
  // Instruction encodings
  // ----------------------------------------

  // Major opcodes
  localparam logic [6:0] op_rtype = 7'b0110011;
  localparam logic [6:0] op_itype = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_system = 7'b1110011;

  // The only SYSTEM word this core accepts
  localparam word_t funct_ebreak = 32'h0010_0073;

  // funct7 values, alt picks SUB and SRA
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // funct3 values of OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // ALU operations, pass_b forwards operand B for LUI
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // ----------------------------------------
  // Instruction format views
  // ----------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One fetched word, read through whichever format applies
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  // ----------------------------------------
  // Pipeline stage payloads
  // ----------------------------------------

  // Decode to execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    alu_op_t   alu_op;
    logic      use_imm;
    logic      use_pc;
    logic      reg_write;
    logic      is_ebreak;
    logic      is_illegal;
  } ex_stage_t;

  // Execute to result
  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     result;
    logic      reg_write;
    logic      is_ebreak;
    logic      is_illegal;
  } res_stage_t;

  // Register write-back, also the forwarding source
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } wb_t;

endpackage

//--- src/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::wb_t       wb
);

  // x1 to x31, x0 is not stored
  rv_pkg::word_t regs [31:1];

  // Write port
  // No writes while reset is held
  always_ff @(posedge clk) begin
    if (rst_n && wb.en && (wb.addr != '0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // ----------------------------------------
  // Read ports with write-through
  // ----------------------------------------

  // x0 reads zero
  // Same-cycle write to the read address returns the new data
  always_comb begin
    if (rs1 == '0) begin
      rs1_data = '0;
    end else if (wb.en && (wb.addr == rs1)) begin
      rs1_data = wb.data;
    end else begin
      rs1_data = regs[rs1];
    end

    if (rs2 == '0) begin
      rs2_data = '0;
    end else if (wb.en && (wb.addr == rs2)) begin
      rs2_data = wb.data;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

//--- src/rv_result.sv
`timescale 1ns/100ps

module rv_result (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_pkg::res_stage_t res,
  output rv_pkg::wb_t        wb,
  output logic               halt,
  output logic               retire_valid,
  output rv_pkg::word_t      retire_pc,
  output rv_pkg::reg_addr_t  retire_rd,
  output rv_pkg::word_t      retire_data,
  output logic               ebreak,
  output logic               trap
);

  logic ebreak_q;
  logic trap_q;
  logic ebreak_hit;
  logic trap_hit;
  logic halting;
  logic writes;

  // ----------------------------------------
  // Halt detection
  // ----------------------------------------

  // Halting word sits in the result register
  assign halting    = res.valid && (res.is_ebreak || res.is_illegal);
  // First halting word only, later ones are already behind the halt
  assign ebreak_hit = res.valid && res.is_ebreak && !halt;
  assign trap_hit   = res.valid && res.is_illegal && !halt;

  // Sticky flags, cleared only by reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ebreak_q <= 1'b0;
      trap_q   <= 1'b0;
    end else begin
      ebreak_q <= ebreak_q || ebreak_hit;
      trap_q   <= trap_q || trap_hit;
    end
  end

  // Flags show in the halting cycle and stay up
  assign ebreak = ebreak_q || ebreak_hit;
  assign trap   = trap_q || trap_hit;
  // Decode sees the halt from the next cycle on
  assign halt   = ebreak_q || trap_q;

  // ----------------------------------------
  // Write-back and retire
  // ----------------------------------------

  // Halting word itself never retires
  assign retire_valid = res.valid && !halting && !halt;
  // x0 and non-writing instructions skip the register file
  assign writes       = retire_valid && res.reg_write && (res.rd != '0);

  assign wb.en   = writes;
  assign wb.addr = res.rd;
  assign wb.data = res.result;

  assign retire_pc   = res.pc;
  assign retire_rd   = writes ? res.rd : '0;
  assign retire_data = writes ? res.result : '0;

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  input  logic reset_req,
  output logic clk,
  output logic rst_n
);

  localparam int half_period = 20;
  localparam int drive_delay = 1;

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Power-on reset, then a fresh two-cycle reset on each request
  // Request is sampled at the rising edge, rst_n moves just after it
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #(drive_delay) rst_n = 1'b1;
    forever begin
      @(posedge clk);
      if (reset_req) begin
        #(drive_delay) rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #(drive_delay) rst_n = 1'b1;
      end
    end
  end

endmodule

//--- testbench/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;

  localparam int clk_period      = 40;
  localparam int drive_delay     = 1;
  localparam int mem_words       = 256;
  localparam int num_tests       = 6;
  localparam int init_len        = 31;
  localparam int tail_len        = 4;
  localparam int settle_cycles   = 3;
  localparam int cycles_per_test = 10;
  localparam logic [31:0] ebreak_word  = 32'h0010_0073;
  // LW x1 0(x0) traps since loads are not decoded by this core
  localparam logic [31:0] illegal_word = 32'h0000_2083;

  // Model register file where index 0 stays zero
  typedef logic [31:0][31:0] regs_t;

  logic              clk;
  logic              rst_n;
  logic              reset_req;
  rv_pkg::word_t     imem_raddr;
  rv_pkg::word_t     imem_rdata;
  logic              retire_valid;
  rv_pkg::word_t     retire_pc;
  rv_pkg::reg_addr_t retire_rd;
  rv_pkg::word_t     retire_data;
  logic              ebreak;
  logic              trap;

  rv_pkg::word_t imem [0:mem_words-1];
  rv_pkg::word_t prog [$];

  regs_t         model_regs;
  rv_pkg::word_t model_pc;
  int            retired;
  int            halt_index;
  int            errors;
  int            failed_tests;

  tb_clock i_clock (
    .reset_req (reset_req),
    .clk       (clk),
    .rst_n     (rst_n)
  );

  rv_core i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_raddr   (imem_raddr),
    .imem_rdata   (imem_rdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .ebreak       (ebreak),
    .trap         (trap)
  );

  // Zero-latency program memory
  assign imem_rdata = imem[imem_raddr[9:2]];

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic rv_pkg::word_t alu_model(input logic [2:0] funct3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
    logic [4:0]    sh;
    rv_pkg::word_t fill;
    rv_pkg::word_t y;
    sh   = b[4:0];
    // Sign fill of SRA covering the top sh bits
    fill = ~(32'hffff_ffff >> sh) & {32{a[31]}};
    case (funct3)
      3'b000: y = alt ? a - b : a + b;
      3'b001: y = a << sh;
      // Differing signs decide a signed compare alone
      3'b010: y = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      3'b011: y = {31'b0, a < b};
      3'b100: y = a ^ b;
      3'b101: y = alt ? ((a >> sh) | fill) : (a >> sh);
      3'b110: y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic void ref_step(
    inout  regs_t             regs,
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     pc,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     value
  );
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t y;
    a = regs[instr[19:15]];
    b = regs[instr[24:20]];
    case (instr[6:0])
      rv_pkg::op_rtype: y = alu_model(instr[14:12], instr[30], a, b);
      // Only SRAI takes bit 30 as the alt select
      rv_pkg::op_itype: y = alu_model(instr[14:12], (instr[14:12] == 3'b101) && instr[30],
                                      a, {{20{instr[31]}}, instr[31:20]});
      rv_pkg::op_lui:   y = {instr[31:12], 12'b0};
      rv_pkg::op_auipc: y = pc + {instr[31:12], 12'b0};
      default:          y = '0;
    endcase
    rd = instr[11:7];
    if (rd == 5'd0) begin
      value = '0;
    end else begin
      regs[rd] = y;
      value    = y;
    end
  endfunction

  // ----------------------------------------
  // Instruction builders
  // ----------------------------------------

  function automatic rv_pkg::reg_addr_t rand_reg();
    logic [31:0] r;
    r = $urandom;
    return r[4:0];
  endfunction

  function automatic rv_pkg::reg_addr_t rand_nz_reg();
    logic [31:0] r;
    r = $urandom;
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  // alt only on ADD/SUB and SRL/SRA
  function automatic rv_pkg::word_t rand_r(input rv_pkg::reg_addr_t rd,
                                           input rv_pkg::reg_addr_t rs1,
                                           input rv_pkg::reg_addr_t rs2);
    logic [31:0] r;
    logic        alt;
    r   = $urandom;
    alt = ((r[2:0] == 3'd0) || (r[2:0] == 3'd5)) && r[3];
    return {1'b0, alt, 5'b0, rs2, rs1, r[2:0], rd, rv_pkg::op_rtype};
  endfunction

  function automatic rv_pkg::word_t rand_i(input rv_pkg::reg_addr_t rd,
                                           input rv_pkg::reg_addr_t rs1);
    logic [31:0] r;
    logic [11:0] imm;
    r = $urandom;
    if (r[2:0] == 3'd1) begin
      imm = {7'b0, r[8:4]};
    end else if (r[2:0] == 3'd5) begin
      imm = {1'b0, r[9], 5'b0, r[8:4]};
    end else begin
      imm = r[31:20];
    end
    return {imm, rs1, r[2:0], rd, rv_pkg::op_itype};
  endfunction

  // LUI or AUIPC
  function automatic rv_pkg::word_t rand_u(input rv_pkg::reg_addr_t rd);
    logic [31:0] r;
    r = $urandom;
    return {r[31:12], rd, r[0] ? rv_pkg::op_lui : rv_pkg::op_auipc};
  endfunction

  function automatic rv_pkg::word_t rand_any(input rv_pkg::reg_addr_t rd,
                                             input rv_pkg::reg_addr_t rs1,
                                             input rv_pkg::reg_addr_t rs2);
    logic [31:0] r;
    r = $urandom;
    case (r[1:0])
      2'd0, 2'd1: return rand_r(rd, rs1, rs2);
      2'd2:       return rand_i(rd, rs1);
      default:    return rand_u(rd);
    endcase
  endfunction

  function automatic string test_name(input int id);
    case (id)
      0: return "register ops";
      1: return "immediate and upper ops";
      2: return "dependent chains";
      3: return "x0 writes and reads";
      4: return "ebreak halt";
      default: return "illegal word trap";
    endcase
  endfunction

  function automatic int body_length(input int id);
    case (id)
      0, 1, 2: return 40;
      3:       return 30;
      default: return 20;
    endcase
  endfunction

  // Init prefix, test body, halting word, then words that must never retire
  task automatic build_program(input int id);
    logic [31:0]       r;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t prev1;
    rv_pkg::reg_addr_t prev2;
    prog.delete();
    prev1 = 5'd1;
    prev2 = 5'd2;
    // ADDI xN, x0, imm gives every register a known value
    for (int i = 1; i <= init_len; i++) begin
      r = $urandom;
      prog.push_back({r[11:0], 5'd0, 3'b000, i[4:0], rv_pkg::op_itype});
    end
    for (int k = 0; k < body_length(id); k++) begin
      r = $urandom;
      case (id)
        0: prog.push_back(rand_r(rand_reg(), rand_reg(), rand_reg()));
        1: prog.push_back((r[1:0] == 2'd3) ? rand_u(rand_reg()) : rand_i(rand_reg(), rand_reg()));
        2: begin
          // Sources are the last two destinations one and two ahead
          rd = rand_nz_reg();
          if (r[1]) begin
            prog.push_back(rand_r(rd, r[0] ? prev1 : prev2, r[0] ? prev2 : prev1));
          end else begin
            prog.push_back(rand_i(rd, r[0] ? prev1 : prev2));
          end
          prev2 = prev1;
          prev1 = rd;
        end
        3: begin
          case (r[1:0])
            2'd0:    prog.push_back(rand_r(5'd0, rand_reg(), rand_reg()));
            2'd1:    prog.push_back(rand_i(5'd0, rand_reg()));
            2'd2:    prog.push_back(rand_r(rand_nz_reg(), 5'd0, 5'd0));
            default: prog.push_back(rand_i(rand_nz_reg(), 5'd0));
          endcase
        end
        default: prog.push_back(rand_any(rand_reg(), rand_reg(), rand_reg()));
      endcase
    end
    halt_index = prog.size();
    prog.push_back((id == num_tests - 1) ? illegal_word : ebreak_word);
    repeat (tail_len) prog.push_back(rand_any(rand_nz_reg(), rand_reg(), rand_reg()));
  endtask

  // Unused words hold opcode zero tagged with their index and are all illegal
  task automatic load_program();
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = {i[24:0], 7'b0};
    end
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    model_regs = '0;
    model_pc   = rv_pkg::reset_pc;
    retired    = 0;
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic check_idle();
    assert (retire_valid === 1'b0) else report_mismatch("retire_valid", retire_valid, 0);
    assert (ebreak === 1'b0) else report_mismatch("ebreak", ebreak, 0);
    assert (trap === 1'b0) else report_mismatch("trap", trap, 0);
    assert (imem_raddr === rv_pkg::reset_pc)
      else report_mismatch("imem_raddr", imem_raddr, rv_pkg::reset_pc);
  endtask

  task automatic check_end(input logic expect_trap);
    assert (retired == halt_index) else report_mismatch("retire count", retired, halt_index);
    assert (ebreak === !expect_trap) else report_mismatch("ebreak", ebreak, !expect_trap);
    assert (trap === expect_trap) else report_mismatch("trap", trap, expect_trap);
  endtask

  // Retire compare sampled mid-cycle
  always @(negedge clk) begin : compare_retire
    rv_pkg::reg_addr_t exp_rd;
    rv_pkg::word_t     exp_data;
    if (rst_n === 1'b1 && retire_valid === 1'b1) begin
      assert (retired < halt_index) else begin
        $display("Error: retire at pc %h after the halting word at %0t", retire_pc, $time);
        errors++;
      end
      if (retired < halt_index) begin
        assert (retire_pc === model_pc) else report_mismatch("retire_pc", retire_pc, model_pc);
        ref_step(model_regs, prog[retired], model_pc, exp_rd, exp_data);
        assert (retire_rd === exp_rd) else report_mismatch("retire_rd", retire_rd, exp_rd);
        assert (retire_data === exp_data)
          else report_mismatch("retire_data", retire_data, exp_data);
        model_pc = model_pc + rv_pkg::pc_step;
        retired++;
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin : run_tests
    int errors_before;
    reset_req    = 1'b0;
    errors       = 0;
    failed_tests = 0;
    void'($urandom(18));
    for (int t = 0; t < num_tests; t++) begin
      errors_before = errors;
      build_program(t);
      load_program();
      // First test rides on the power-on reset
      if (t > 0) begin
        reset_req = 1'b1;
        @(posedge clk);
        #(drive_delay) reset_req = 1'b0;
      end
      @(posedge rst_n);
      #(drive_delay);
      check_idle();
      while (ebreak !== 1'b1 && trap !== 1'b1) begin
        @(negedge clk);
      end
      // Give a stray retire time to show
      repeat (settle_cycles) @(negedge clk);
      @(posedge clk);
      #(drive_delay);
      check_end(t == num_tests - 1);
      if (errors == errors_before) begin
        $display("Test %0d %s: passed, %0d retired", t, test_name(t), retired);
      end else begin
        failed_tests++;
        $display("Test %0d %s: failed, %0d retired", t, test_name(t), retired);
      end
    end
    $display("Tests run %0d, tests failed %0d, check errors %0d",
             num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Program lengths plus reset and drain slack per test
  initial begin : watchdog
    int total;
    total = 0;
    for (int t = 0; t < num_tests; t++) begin
      total += init_len + body_length(t) + 1 + tail_len + cycles_per_test;
    end
    #(total * clk_period);
    $display("Watchdog timeout: the run did not finish within %0d cycles", total);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- verilog.f
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv
